/* hw/exec_pipe_defines.svh */
`ifndef EXEC_PIPE_DEFINES_SVH
`define EXEC_PIPE_DEFINES_SVH

`define EP_XLEN 32
`define EP_NREG 32

`define TY_BASE 6'b100000
`define ADDI    6'b101000
`define ORI     6'b101100
`define XORI    6'b101011
`define MOVI    6'b100010

`define ADD   5'b00000
`define SUB   5'b00001
`define AND   5'b00010
`define XOR   5'b00011
`define OR    5'b00100
`define SLLI  5'b01000
`define SRLI  5'b01001
`define ROTRI 5'b01011

`define EP_F_OPCODE 30:25
`define EP_F_RT     24:20
`define EP_F_RA     19:15
`define EP_F_RB     14:10
`define EP_F_SUB    4:0
`define EP_F_IMM15  14:0
`define EP_F_IMM20  19:0

`define EP_ADR_STATUS 6'd32
`define EP_ADR_ISSUE  6'd33

`endif

/* hw/exec_pipe_pkg.sv */
`default_nettype none

`include "exec_pipe_defines.svh"

package exec_pipe_pkg;

	typedef logic [`EP_XLEN-1:0] word_t;
	typedef logic [$clog2(`EP_NREG)-1:0] reg_idx_t;
	typedef logic [5:0] opcode_t;
	typedef logic [4:0] sub_op_t;
	typedef logic [5:0] wb_adr_t; // word address.

	// host side of the wishbone port.
	typedef enum logic [1:0] {
		HOST_IDLE,
		HOST_ACK,
		HOST_DRAIN
	} host_state_e;

endpackage

`default_nettype wire

/* hw/wb_host_port.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_pipe_defines.svh"

module wb_host_port import exec_pipe_pkg::*; (
	input  wire logic    clk,
	input  wire logic    reset,
	input  wire logic    wb_cyc,
	input  wire logic    wb_stb,
	input  wire logic    wb_we,
	input  wire wb_adr_t wb_adr,
	input  wire word_t   wb_dat_w,
	input  wire logic    wb_valid,
	input  wire logic    wb_overflow,
	input  wire word_t   wb_data,
	input  wire logic    ex_illegal,
	input  wire logic    busy,
	output logic         wb_ack,
	output word_t        wb_dat_r,
	output logic         issue_valid,
	output word_t        issue_instr,
	output reg_idx_t     rd_idx,
	input  wire word_t   rd_data
);

	host_state_e state;
	logic ovf_flag;
	logic zero_flag;
	logic ill_flag;
	logic wr_req;
	logic rd_done;
	word_t rd_mux;

	assign wr_req = (state == HOST_IDLE) && wb_cyc && wb_stb && wb_we;
	assign rd_done = (state == HOST_DRAIN) && !busy && !ex_illegal; // pipe empty and flags settled.
	assign rd_idx = reg_idx_t'(wb_adr[4:0]);

	always_comb begin
		if (wb_adr == `EP_ADR_STATUS)
			rd_mux = {{(`EP_XLEN-3){1'b0}}, ill_flag, zero_flag, ovf_flag};
		else if (!wb_adr[5])
			rd_mux = rd_data;
		else
			rd_mux = '0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= HOST_IDLE;
			wb_ack <= 1'b0;
			issue_valid <= 1'b0;
		end else begin
			wb_ack <= 1'b0;
			issue_valid <= 1'b0;
			case (state)
				HOST_IDLE: begin
					if (wr_req) begin
						wb_ack <= 1'b1;
						issue_valid <= (wb_adr == `EP_ADR_ISSUE);
						state <= HOST_ACK;
					end else if (wb_cyc && wb_stb) begin
						state <= HOST_DRAIN;
					end
				end
				HOST_DRAIN: begin
					if (rd_done) begin
						wb_ack <= 1'b1;
						state <= HOST_ACK;
					end
				end
				HOST_ACK: state <= HOST_IDLE; // master drops stb here.
				default: state <= HOST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_req)
			issue_instr <= wb_dat_w;
		if (rd_done)
			wb_dat_r <= rd_mux;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ovf_flag <= 1'b0;
			zero_flag <= 1'b0;
			ill_flag <= 1'b0;
		end else begin
			if (wr_req && (wb_adr == `EP_ADR_STATUS)) begin
				ovf_flag <= 1'b0;
				ill_flag <= 1'b0;
			end
			if (wb_valid) begin
				if (wb_overflow)
					ovf_flag <= 1'b1;
				zero_flag <= (wb_data == '0);
			end
			if (ex_illegal)
				ill_flag <= 1'b1; // new event wins over clear.
		end
	end

	a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> (wb_cyc && wb_stb));

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_pipe_defines.svh"

module decode_stage import exec_pipe_pkg::*; (
	input  wire logic  clk,
	input  wire logic  reset,
	input  wire logic  issue_valid,
	input  wire word_t issue_instr,
	output logic       dec_valid,
	output logic       dec_illegal,
	output opcode_t    dec_opcode,
	output sub_op_t    dec_sub_op,
	output reg_idx_t   dec_rt,
	output reg_idx_t   dec_ra,
	output reg_idx_t   dec_rb,
	output word_t      dec_imm,
	output logic       dec_use_imm
);

	opcode_t opc;
	sub_op_t sub;
	logic legal;
	logic use_imm;
	word_t imm;

	assign opc = issue_instr[`EP_F_OPCODE];
	assign sub = issue_instr[`EP_F_SUB];

	always_comb begin
		legal = 1'b1;
		use_imm = 1'b1;
		imm = '0;
		case (opc)
			`TY_BASE: begin
				imm = word_t'(issue_instr[`EP_F_RB]); // shift amount.
				case (sub)
					`ADD, `SUB, `AND, `OR, `XOR: use_imm = 1'b0;
					`SRLI, `SLLI, `ROTRI: use_imm = 1'b1;
					default: legal = 1'b0;
				endcase
			end
			`ADDI: imm = {{(`EP_XLEN-15){issue_instr[14]}}, issue_instr[`EP_F_IMM15]};
			`ORI, `XORI: imm = word_t'(issue_instr[`EP_F_IMM15]);
			`MOVI: imm = {{(`EP_XLEN-20){issue_instr[19]}}, issue_instr[`EP_F_IMM20]};
			default: begin
				legal = 1'b0; // loads, stores, branches, unknown.
				use_imm = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
			dec_illegal <= 1'b0;
		end else begin
			dec_valid <= issue_valid;
			dec_illegal <= issue_valid && !legal;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			dec_opcode <= opc;
			dec_sub_op <= sub;
			dec_rt <= issue_instr[`EP_F_RT];
			dec_ra <= issue_instr[`EP_F_RA];
			dec_rb <= issue_instr[`EP_F_RB];
			dec_imm <= imm;
			dec_use_imm <= use_imm;
		end
	end

endmodule

`default_nettype wire

/* hw/operand_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_pipe_defines.svh"

module operand_stage import exec_pipe_pkg::*; (
	input  wire logic     clk,
	input  wire logic     reset,
	input  wire logic     dec_valid,
	input  wire logic     dec_illegal,
	input  wire opcode_t  dec_opcode,
	input  wire sub_op_t  dec_sub_op,
	input  wire reg_idx_t dec_rt,
	input  wire reg_idx_t dec_ra,
	input  wire reg_idx_t dec_rb,
	input  wire word_t    dec_imm,
	input  wire logic     dec_use_imm,
	input  wire logic     wb_valid,
	input  wire reg_idx_t wb_rt,
	input  wire word_t    wb_data,
	input  wire reg_idx_t rd_idx,
	output logic          op_valid,
	output logic          op_illegal,
	output opcode_t       op_opcode,
	output sub_op_t       op_sub_op,
	output reg_idx_t      op_rt,
	output word_t         op_src1,
	output word_t         op_src2,
	output word_t         rd_data,
	output logic          busy_part
);

	word_t regs [`EP_NREG];
	word_t ra_val;
	word_t rb_val;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `EP_NREG; i++)
				regs[i] <= '0;
		end else if (wb_valid) begin
			regs[wb_rt] <= wb_data;
		end
	end

	// writeback lands on the same edge as this read.
	assign ra_val = (wb_valid && (wb_rt == dec_ra)) ? wb_data : regs[dec_ra];
	assign rb_val = (wb_valid && (wb_rt == dec_rb)) ? wb_data : regs[dec_rb];
	assign rd_data = regs[rd_idx];
	assign busy_part = dec_valid || op_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			op_valid <= 1'b0;
			op_illegal <= 1'b0;
		end else begin
			op_valid <= dec_valid;
			op_illegal <= dec_valid && dec_illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			op_opcode <= dec_opcode;
			op_sub_op <= dec_sub_op;
			op_rt <= dec_rt;
			op_src1 <= (dec_opcode == `MOVI) ? dec_imm : ra_val;
			op_src2 <= dec_use_imm ? dec_imm : rb_val;
		end
	end

	a_wb_idx_known: assert property (@(posedge clk) disable iff (reset)
		wb_valid |-> !$isunknown(wb_rt));

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_pipe_defines.svh"

module alu import exec_pipe_pkg::*; (
	input  wire logic     clk,
	input  wire logic     reset,
	input  wire logic     op_valid,
	input  wire logic     op_illegal,
	input  wire opcode_t  op_opcode,
	input  wire sub_op_t  op_sub_op,
	input  wire reg_idx_t op_rt,
	input  wire word_t    op_src1,
	input  wire word_t    op_src2,
	output logic          wb_valid,
	output reg_idx_t      wb_rt,
	output word_t         wb_data,
	output logic          wb_overflow,
	output logic          ex_illegal
);

	word_t sum;
	word_t diff;
	logic c30;
	logic c31;
	logic b30;
	logic b31;
	logic [2*`EP_XLEN-1:0] rot;
	word_t result;
	logic overflow;

	// sum and difference split at bit 31 for the overflow rule.
	always_comb begin
		{c30, sum[30:0]} = {1'b0, op_src1[30:0]} + {1'b0, op_src2[30:0]};
		{c31, sum[31]} = {1'b0, op_src1[31]} + {1'b0, op_src2[31]} + {1'b0, c30};
		{b30, diff[30:0]} = {1'b0, op_src1[30:0]} - {1'b0, op_src2[30:0]};
		{b31, diff[31]} = {1'b0, op_src1[31]} - {1'b0, op_src2[31]} - {1'b0, b30};
		rot = {op_src1, op_src1} >> op_src2[4:0];
	end

	always_comb begin
		result = '0;
		overflow = 1'b0;
		case (op_opcode)
			`TY_BASE: begin
				case (op_sub_op)
					`ADD: begin
						result = sum;
						overflow = c30 ^ c31;
					end
					`SUB: begin
						result = diff;
						overflow = b30 ^ b31; // borrow in vs borrow out.
					end
					`AND: result = op_src1 & op_src2;
					`OR: result = op_src1 | op_src2;
					`XOR: result = op_src1 ^ op_src2;
					`SRLI: result = op_src1 >> op_src2[4:0];
					`SLLI: result = op_src1 << op_src2[4:0];
					`ROTRI: result = rot[`EP_XLEN-1:0];
					default: result = '0;
				endcase
			end
			`ADDI: begin
				result = sum;
				overflow = c30 ^ c31;
			end
			`ORI: result = op_src1 | op_src2;
			`XORI: result = op_src1 ^ op_src2;
			`MOVI: result = op_src1;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
			ex_illegal <= 1'b0;
		end else begin
			wb_valid <= op_valid && !op_illegal;
			ex_illegal <= op_valid && op_illegal; // one cycle only.
		end
	end

	always_ff @(posedge clk) begin
		if (op_valid) begin
			wb_rt <= op_rt;
			wb_data <= result;
			wb_overflow <= overflow;
		end
	end

	a_wb_xor_illegal: assert property (@(posedge clk) disable iff (reset)
		!(wb_valid && ex_illegal));

endmodule

`default_nettype wire

/* hw/exec_pipe_top.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_pipe_top import exec_pipe_pkg::*; (
	input  wire logic    clk,
	input  wire logic    reset,
	input  wire logic    wb_cyc,
	input  wire logic    wb_stb,
	input  wire logic    wb_we,
	input  wire wb_adr_t wb_adr,
	input  wire word_t   wb_dat_w,
	output word_t        wb_dat_r,
	output logic         wb_ack
);

	logic issue_valid;
	word_t issue_instr;
	reg_idx_t rd_idx;
	word_t rd_data;
	logic busy_part;
	logic busy;

	logic dec_valid;
	logic dec_illegal;
	opcode_t dec_opcode;
	sub_op_t dec_sub_op;
	reg_idx_t dec_rt;
	reg_idx_t dec_ra;
	reg_idx_t dec_rb;
	word_t dec_imm;
	logic dec_use_imm;

	logic op_valid;
	logic op_illegal;
	opcode_t op_opcode;
	sub_op_t op_sub_op;
	reg_idx_t op_rt;
	word_t op_src1;
	word_t op_src2;

	logic wb_valid;
	reg_idx_t wb_rt;
	word_t wb_data;
	logic wb_overflow;
	logic ex_illegal;

	assign busy = busy_part || wb_valid; // writeback still pending.

	wb_host_port u_host (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_valid(wb_valid),
		.wb_overflow(wb_overflow),
		.wb_data(wb_data),
		.ex_illegal(ex_illegal),
		.busy(busy),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r),
		.issue_valid(issue_valid),
		.issue_instr(issue_instr),
		.rd_idx(rd_idx),
		.rd_data(rd_data)
	);

	decode_stage u_decode (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_instr(issue_instr),
		.dec_valid(dec_valid),
		.dec_illegal(dec_illegal),
		.dec_opcode(dec_opcode),
		.dec_sub_op(dec_sub_op),
		.dec_rt(dec_rt),
		.dec_ra(dec_ra),
		.dec_rb(dec_rb),
		.dec_imm(dec_imm),
		.dec_use_imm(dec_use_imm)
	);

	operand_stage u_operand (
		.clk(clk),
		.reset(reset),
		.dec_valid(dec_valid),
		.dec_illegal(dec_illegal),
		.dec_opcode(dec_opcode),
		.dec_sub_op(dec_sub_op),
		.dec_rt(dec_rt),
		.dec_ra(dec_ra),
		.dec_rb(dec_rb),
		.dec_imm(dec_imm),
		.dec_use_imm(dec_use_imm),
		.wb_valid(wb_valid),
		.wb_rt(wb_rt),
		.wb_data(wb_data),
		.rd_idx(rd_idx),
		.op_valid(op_valid),
		.op_illegal(op_illegal),
		.op_opcode(op_opcode),
		.op_sub_op(op_sub_op),
		.op_rt(op_rt),
		.op_src1(op_src1),
		.op_src2(op_src2),
		.rd_data(rd_data),
		.busy_part(busy_part)
	);

	alu u_alu (
		.clk(clk),
		.reset(reset),
		.op_valid(op_valid),
		.op_illegal(op_illegal),
		.op_opcode(op_opcode),
		.op_sub_op(op_sub_op),
		.op_rt(op_rt),
		.op_src1(op_src1),
		.op_src2(op_src2),
		.wb_valid(wb_valid),
		.wb_rt(wb_rt),
		.wb_data(wb_data),
		.wb_overflow(wb_overflow),
		.ex_illegal(ex_illegal)
	);

endmodule

`default_nettype wire

/* tb/exec_pipe_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_pipe_defines.svh"

module exec_pipe_tb import exec_pipe_pkg::*;;

	localparam int ACK_TIMEOUT = 64;

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_adr_t wb_adr;
	word_t wb_dat_w;
	word_t wb_dat_r;
	logic wb_ack;

	word_t model_regs [32];
	logic model_ovf;
	logic model_zero;
	logic model_ill;
	int err_count;
	int check_count;
	int test_count;
	int test_errs_start;
	sub_op_t base_ops [8] = '{`ADD, `SUB, `AND, `OR, `XOR, `SRLI, `SLLI, `ROTRI};
	opcode_t ill_ops [6] = '{6'b000010, 6'b001010, 6'b100110, 6'b100100, 6'b111111, 6'b000000};

	exec_pipe_top u_dut (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic word_t enc_base(input sub_op_t sub, input reg_idx_t rt,
			input reg_idx_t ra, input reg_idx_t rb);
		return {1'b0, `TY_BASE, rt, ra, rb, 5'b0, sub};
	endfunction

	function automatic word_t enc_imm(input opcode_t opc, input reg_idx_t rt,
			input reg_idx_t ra, input logic [14:0] imm);
		return {1'b0, opc, rt, ra, imm};
	endfunction

	function automatic word_t enc_movi(input reg_idx_t rt, input logic [19:0] imm);
		return {1'b0, `MOVI, rt, imm};
	endfunction

	function automatic word_t random_instr(input reg_idx_t rt, input reg_idx_t ra,
			input reg_idx_t rb);
		int unsigned k;
		logic [14:0] imm;
		k = $urandom % 11;
		imm = 15'($urandom);
		if (k < 8)
			return enc_base(base_ops[k[2:0]], rt, ra, rb);
		else if (k == 8)
			return enc_imm(`ADDI, rt, ra, imm);
		else if (k == 9)
			return enc_imm(`ORI, rt, ra, imm);
		else
			return enc_imm(`XORI, rt, ra, imm);
	endfunction

	// {overflow, sum}; overflow is carry into bit 31 xor carry out.
	function automatic logic [32:0] add_ovf(input word_t a, input word_t b, input logic cin);
		logic [32:0] s;
		logic c_in31;
		s = {1'b0, a} + {1'b0, b} + {32'b0, cin};
		c_in31 = s[31] ^ a[31] ^ b[31];
		return {c_in31 ^ s[32], s[31:0]};
	endfunction

	function automatic void ref_exec(input word_t instr);
		opcode_t opc;
		sub_op_t sub;
		reg_idx_t rt;
		logic [4:0] sh;
		word_t a;
		word_t b;
		word_t r;
		logic ovf;
		logic legal;
		opc = instr[30:25];
		sub = instr[4:0];
		rt = instr[24:20];
		sh = instr[14:10];
		a = model_regs[instr[19:15]];
		b = model_regs[instr[14:10]];
		r = '0;
		ovf = 1'b0;
		legal = 1'b1;
		case (opc)
			`TY_BASE: begin
				case (sub)
					`ADD: {ovf, r} = add_ovf(a, b, 1'b0);
					`SUB: {ovf, r} = add_ovf(a, ~b, 1'b1); // a + ~b + 1.
					`AND: r = a & b;
					`OR: r = a | b;
					`XOR: r = a ^ b;
					`SRLI: r = a >> sh;
					`SLLI: r = a << sh;
					`ROTRI: r = (a >> sh) | (a << (6'd32 - {1'b0, sh}));
					default: legal = 1'b0;
				endcase
			end
			`ADDI: {ovf, r} = add_ovf(a, {{17{instr[14]}}, instr[14:0]}, 1'b0);
			`ORI: r = a | {17'b0, instr[14:0]};
			`XORI: r = a ^ {17'b0, instr[14:0]};
			`MOVI: r = {{12{instr[19]}}, instr[19:0]};
			default: legal = 1'b0;
		endcase
		if (legal) begin
			model_regs[rt] = r;
			if (ovf)
				model_ovf = 1'b1;
			model_zero = (r == '0);
		end else begin
			model_ill = 1'b1; // nothing written.
		end
	endfunction

	task automatic give_up(input string what);
		$display("timeout: the DUT never acknowledged the %s", what);
		$display("Result: FAILED");
		$finish;
	endtask

	// bus tasks start and end 1 ns after a rising edge.
	task automatic wb_write(input wb_adr_t adr, input word_t data);
		int waited;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = data;
		waited = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > ACK_TIMEOUT)
				give_up("write");
		end while (!wb_ack);
		@(posedge clk); // ack is sampled at this edge.
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_read(input wb_adr_t adr, output word_t data);
		int waited;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		waited = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > ACK_TIMEOUT)
				give_up("read");
		end while (!wb_ack);
		data = wb_dat_r;
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic issue(input word_t instr);
		wb_write(`EP_ADR_ISSUE, instr);
		ref_exec(instr);
	endtask

	task automatic check_reg(input reg_idx_t idx);
		word_t got;
		wb_read({1'b0, idx}, got);
		check_value($sformatf("r%0d", idx), got, model_regs[idx]);
	endtask

	task automatic check_all_regs();
		for (int i = 0; i < 32; i++)
			check_reg(5'(i));
	endtask

	task automatic check_status();
		word_t got;
		wb_read(`EP_ADR_STATUS, got);
		check_value("status", got, {29'b0, model_ill, model_zero, model_ovf});
	endtask

	task automatic clear_flags();
		wb_write(`EP_ADR_STATUS, '0);
		model_ovf = 1'b0;
		model_ill = 1'b0;
	endtask

	task automatic report_test(input string name);
		test_count++;
		if (err_count == test_errs_start)
			$display("test %0d %s: ok", test_count, name);
		else
			$display("test %0d %s: %0d errors", test_count, name, err_count - test_errs_start);
		test_errs_start = err_count;
	endtask

	initial begin
		reg_idx_t prev;
		reg_idx_t prev2;
		reg_idx_t rt;
		void'($urandom(82311));
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		model_ovf = 1'b0;
		model_zero = 1'b0;
		model_ill = 1'b0;
		err_count = 0;
		check_count = 0;
		test_count = 0;
		test_errs_start = 0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < 32; i++)
			issue(enc_movi(5'(i), 20'($urandom)));
		check_all_regs();
		report_test("movi_all_regs");

		for (int i = 0; i < 200; i++) begin
			rt = 5'($urandom);
			issue(random_instr(rt, 5'($urandom), 5'($urandom)));
			check_reg(rt);
		end
		report_test("random_ops");

		clear_flags();
		issue(enc_movi(5'd1, 20'h7ffff));
		issue(enc_base(`SLLI, 5'd1, 5'd1, 5'd12));
		issue(enc_imm(`ORI, 5'd1, 5'd1, 15'h0fff)); // r1 = 7fffffff.
		issue(enc_movi(5'd2, 20'h00001));
		issue(enc_movi(5'd4, 20'h80000));
		issue(enc_base(`SLLI, 5'd4, 5'd4, 5'd12)); // r4 = 80000000.
		issue(enc_base(`ADD, 5'd3, 5'd2, 5'd2));
		check_status();
		issue(enc_base(`ADD, 5'd3, 5'd1, 5'd2));
		check_reg(5'd3);
		check_status();
		clear_flags();
		check_status();
		issue(enc_base(`SUB, 5'd5, 5'd4, 5'd2));
		check_reg(5'd5);
		check_status();
		clear_flags();
		issue(enc_base(`SUB, 5'd5, 5'd2, 5'd4));
		check_status();
		clear_flags();
		issue(enc_base(`SUB, 5'd5, 5'd4, 5'd4));
		check_reg(5'd5);
		check_status();
		issue(enc_imm(`ADDI, 5'd3, 5'd1, 15'h0001));
		check_status();
		report_test("overflow");

		issue(enc_movi(5'd1, 20'($urandom)));
		issue(enc_base(`SLLI, 5'd1, 5'd1, 5'd12));
		issue(enc_imm(`ORI, 5'd1, 5'd1, {3'b0, 12'($urandom)}));
		for (int sh = 0; sh < 32; sh++) begin
			issue(enc_base(`SRLI, 5'd2, 5'd1, 5'(sh)));
			check_reg(5'd2);
			issue(enc_base(`SLLI, 5'd2, 5'd1, 5'(sh)));
			check_reg(5'd2);
			issue(enc_base(`ROTRI, 5'd2, 5'd1, 5'(sh)));
			check_reg(5'd2);
		end
		report_test("shifts");

		clear_flags();
		issue(enc_base(`XOR, 5'd6, 5'd7, 5'd7)); // zero result.
		for (int i = 0; i < 6; i++) begin
			issue({1'b0, ill_ops[i], 25'($urandom)});
			check_status();
		end
		issue(enc_base(5'b11111, 5'd8, 5'd9, 5'd10)); // unknown sub-opcode.
		issue(enc_base(5'b10000, 5'd9, 5'd8, 5'd10));
		check_all_regs();
		check_status();
		issue(enc_movi(5'd6, 20'h00123));
		issue({1'b0, ill_ops[0], 25'($urandom)});
		check_status();
		report_test("illegal");

		prev = 5'd20;
		prev2 = 5'd21;
		issue(enc_movi(prev, 20'($urandom)));
		issue(enc_movi(prev2, 20'($urandom)));
		for (int i = 0; i < 40; i++) begin
			rt = 5'($urandom);
			issue(random_instr(rt, prev, prev2));
			prev2 = prev;
			prev = rt;
		end
		check_all_regs();
		check_status();
		report_test("bypass_chain");

		$display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
		if (err_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* exec_pipe.f */
+incdir+hw
hw/exec_pipe_pkg.sv
hw/wb_host_port.sv
hw/decode_stage.sv
hw/operand_stage.sv
hw/alu.sv
hw/exec_pipe_top.sv
tb/exec_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the exec_pipe testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module exec_pipe_tb -f exec_pipe.f -o exec_pipe_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/exec_pipe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
	exit 1
fi
exit 0
